// ==== cop_link.f ====
+incdir+verification
common/cop_pkg.sv
mcu_bridge/mcu_port_latch.sv
mcu_bridge/bank_config.sv
logic/rom_bank_map.sv
logic/cop_link.sv
verification/cop_link_tb.sv

// ==== Bender.yml ====
package:
  name: cop_link

sources:
  - common/cop_pkg.sv
  - mcu_bridge/mcu_port_latch.sv
  - mcu_bridge/bank_config.sv
  - logic/rom_bank_map.sv
  - logic/cop_link.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cop_link_tb.sv

// ==== verification/cop_link_tests.svh ====
// Directed cop_link tests, included into the testbench module

    // One sound read that drives new_p1 on p1_o once the access runs
    task automatic read_snd(input snd_addr_t addr, input sndflag_t bank, input mcu_byte_t new_p1);
        int n;
        n        = 0;
        snd_addr = addr;
        snd_cs   = 1'b1;
        do begin
            next_cycle();
            n++;
        end while (mem_cs !== 1'b1 && n < 20);
        checks++;
        assert (mem_cs === 1'b1) else begin
            $display("%s: sound read of %h started no ROM access", test_name, addr);
            errors++;
        end
        check_value("sound mem_addr", snd_rom_addr(addr, bank), mem_addr);
        p1_o = new_p1;
        while (snd_ok !== 1'b1 && n < 40) begin
            next_cycle();
            n++;
            // The access keeps the bank it started with
            if (mem_cs === 1'b1) begin
                check_value("sound mem_addr in flight", snd_rom_addr(addr, bank), mem_addr);
            end
        end
        checks++;
        assert (snd_ok === 1'b1) else begin
            $display("%s: snd_ok never rose for address %h", test_name, addr);
            errors++;
        end
        check_value("snd_data", rom_byte(snd_rom_addr(addr, bank)), snd_data);
        pcm_served_last = 1'b0;
        snd_cs = 1'b0;
        next_cycle();
    endtask

    task automatic test_reset();
        begin_test("reset");
        check_value("mcu_intn", 1, mcu_intn);
        check_value("mem_cs", 0, mem_cs);
        check_value("snd_ok", 0, snd_ok);
        check_value("adpcm_ok", 0, adpcm_ok);
        check_value("p0_i", 0, p0_i);
        check_value("mcu_dout", 0, mcu_dout);
        end_test();
    endtask

    task automatic test_interrupt();
        begin_test("interrupt");
        p2_o[3] = 1'b1;
        wait_cycles(2);
        sec0 = 1'b1;
        next_cycle();
        check_value("mcu_intn one edge after sec0", 1, mcu_intn);
        next_cycle();
        check_value("mcu_intn two edges after sec0", 0, mcu_intn);
        sec0 = 1'b0;
        wait_cycles(2);
        check_value("mcu_intn held low", 0, mcu_intn);
        p2_o[3] = 1'b0;
        wait_cycles(2);
        check_value("mcu_intn after bit 3 low", 1, mcu_intn);
        end_test();
    endtask

    task automatic test_byte_transfer();
        mcu_byte_t lo;
        mcu_byte_t hi;
        begin_test("byte transfer");
        mcu_din = cpu_word_t'($random(seed));
        lo      = mcu_byte_t'($random(seed));
        hi      = mcu_byte_t'($random(seed));
        p2_o[4] = 1'b1;
        wait_cycles(2);
        check_value("p0_i high byte", mcu_din[15:8], p0_i);
        p2_o[4] = 1'b0;
        p2_o[5] = 1'b1;
        wait_cycles(2);
        check_value("p0_i low byte", mcu_din[7:0], p0_i);
        p0_o    = lo;
        p2_o[6] = 1'b1;
        wait_cycles(2);
        p0_o    = hi;
        p2_o[7] = 1'b1;
        wait_cycles(2);
        check_value("mcu_dout", {hi, lo}, mcu_dout);
        p2_o[7:4] = 4'h0;
        for (int i = 0; i < 4; i++) begin
            cpu_sec = 3'($random(seed));
            p3_o    = mcu_byte_t'($random(seed));
            #1;
            check_value("p3_i", {cpu_sec, p3_o[4:0]}, p3_i);
            next_cycle();
        end
        end_test();
    endtask

    task automatic test_snd_map();
        snd_addr_t addr;
        begin_test("sound mapping");
        for (int bank = 0; bank < 4; bank++) begin
            p1_o = {1'b0, sndflag_t'(bank), 5'h00};
            wait_cycles(2);
            addr = snd_addr_t'($random(seed));
            read_snd({1'b0, addr[14:0]}, sndflag_t'(bank), p1_o);
            read_snd({1'b1, addr[14:0]}, sndflag_t'(bank), p1_o);
        end
        end_test();
    endtask

    task automatic test_deferred_bank();
        snd_addr_t addr;
        begin_test("deferred bank");
        p1_o = 8'h20;
        wait_cycles(2);
        addr        = snd_addr_t'($random(seed)) | 16'h8000;
        fixed_delay = 4;
        // Bank 3 arrives while the bank 1 fetch is still in flight
        read_snd(addr, 2'd1, 8'h60);
        fixed_delay = 0;
        read_snd(addr, 2'd3, 8'h60);
        end_test();
    endtask

    task automatic test_sharing();
        snd_addr_t s_addr;
        pcm_addr_t a_addr;
        crback_t   bank;
        logic      pcm_first;
        logic      cs_before;
        int        accesses;
        int        n;
        begin_test("sharing");
        for (int round = 0; round < 4; round++) begin
            bank = crback_t'(round * 3 + 1);
            p3_o = mcu_byte_t'(bank);
            wait_cycles(2);
            s_addr     = snd_addr_t'($random(seed));
            a_addr     = pcm_addr_t'($random(seed));
            pcm_first  = !pcm_served_last;
            accesses   = 0;
            cs_before  = 1'b0;
            n          = 0;
            snd_addr   = s_addr;
            adpcm_addr = a_addr;
            snd_cs     = 1'b1;
            adpcm_cs   = 1'b1;
            while (!(snd_ok === 1'b1 && adpcm_ok === 1'b1) && n < 40) begin
                next_cycle();
                n++;
                if (mem_cs === 1'b1 && !cs_before) begin
                    // First access goes to the requester not served last
                    if ((accesses == 0) == pcm_first) begin
                        check_value("ADPCM mem_addr", pcm_rom_addr(a_addr, bank), mem_addr);
                    end else begin
                        check_value("sound mem_addr", snd_rom_addr(s_addr, p1_o[6:5]), mem_addr);
                    end
                    accesses++;
                end
                cs_before = (mem_cs === 1'b1);
            end
            checks++;
            assert (snd_ok === 1'b1 && adpcm_ok === 1'b1) else begin
                $display("%s: both requesters were not served in round %0d", test_name, round);
                errors++;
            end
            check_value("ROM accesses", 2, accesses);
            check_value("snd_data", rom_byte(snd_rom_addr(s_addr, p1_o[6:5])), snd_data);
            check_value("adpcm_data", rom_byte(pcm_rom_addr(a_addr, bank)), adpcm_data);
            pcm_served_last = !pcm_first;
            snd_cs   = 1'b0;
            adpcm_cs = 1'b0;
            next_cycle();
        end
        end_test();
    endtask

// ==== verification/cop_link_tb.sv ====
// Testbench for cop_link with a sound ROM model, run limit and test report

`timescale 1ns/1ps

module cop_link_tb;
    import cop_pkg::*;

    localparam mem_addr_t snd_base = 22'h100000;
    localparam mem_addr_t pcm_base = 22'h240000;
    // Run limit well above the summed length of all tests
    localparam int cycle_limit = 2000;

    logic       clk24;
    logic       rst_n;
    logic       sec0;
    cpu_word_t  mcu_din;
    logic [2:0] cpu_sec;
    cpu_word_t  mcu_dout;
    mcu_byte_t  p0_o;
    mcu_byte_t  p1_o;
    mcu_byte_t  p2_o;
    mcu_byte_t  p3_o;
    mcu_byte_t  p0_i;
    mcu_byte_t  p3_i;
    logic       mcu_intn;
    logic       snd_cs;
    snd_addr_t  snd_addr;
    mcu_byte_t  snd_data;
    logic       snd_ok;
    logic       adpcm_cs;
    pcm_addr_t  adpcm_addr;
    mcu_byte_t  adpcm_data;
    logic       adpcm_ok;
    logic       mem_cs;
    mem_addr_t  mem_addr;
    mcu_byte_t  mem_data;
    logic       mem_ok;

    integer     seed = 32'h2de2abb3;
    integer     mem_seed = 32'h2de2abb3;
    // Latency forced by a test, zero picks a random one
    int         fixed_delay = 0;
    // Requester that the mapper served last
    logic       pcm_served_last = 1'b0;
    string      test_name;
    int         errors_at_start;
    int         errors = 0;
    int         checks = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         cycles = 0;

    cop_link #(
        .snd_base (snd_base),
        .pcm_base (pcm_base)
    ) u_dut (.*);

    initial begin
        clk24 = 1'b0;
        forever #20 clk24 = ~clk24;
    end

    always @(posedge clk24) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk24);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // ROM content seen by the mapper
    function automatic mcu_byte_t rom_byte(input mem_addr_t addr);
        return addr[7:0] ^ 8'h5a;
    endfunction

    function automatic mem_addr_t snd_rom_addr(input snd_addr_t addr, input sndflag_t bank);
        if (addr < 16'h8000) begin
            return snd_base + addr;
        end
        return snd_base + 22'h8000 + bank * 22'h8000 + addr[14:0];
    endfunction

    function automatic mem_addr_t pcm_rom_addr(input pcm_addr_t addr, input crback_t bank);
        return pcm_base + bank * 22'h10000 + addr[15:0];
    endfunction

    // ROM answers each access after 1 to 4 cycles
    always begin : rom_model
        int latency;
        @(posedge clk24);
        #2;
        if (mem_cs === 1'b1) begin
            latency = (fixed_delay != 0) ? fixed_delay : 1 + ($unsigned($random(mem_seed)) % 4);
            repeat (latency - 1) next_cycle();
            mem_data = rom_byte(mem_addr);
            mem_ok   = 1'b1;
            next_cycle();
            mem_ok   = 1'b0;
        end
    end

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    `include "cop_link_tests.svh"

    initial begin
        rst_n      = 1'b0;
        sec0       = 1'b0;
        mcu_din    = '0;
        cpu_sec    = '0;
        p0_o       = '0;
        p1_o       = '0;
        p2_o       = '0;
        p3_o       = '0;
        snd_cs     = 1'b0;
        snd_addr   = '0;
        adpcm_cs   = 1'b0;
        adpcm_addr = '0;
        mem_data   = '0;
        mem_ok     = 1'b0;
        repeat (10) @(posedge clk24);
        #2;
        rst_n = 1'b1;
        next_cycle();
        test_reset();
        test_interrupt();
        test_byte_transfer();
        test_snd_map();
        test_deferred_bank();
        test_sharing();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== logic/cop_link.sv ====
// cop_link top: MCU bridge, bank registers and sound ROM mapper

`timescale 1ns/1ps

module cop_link #(
    parameter cop_pkg::mem_addr_t snd_base = 22'h000000,
    parameter cop_pkg::mem_addr_t pcm_base = 22'h040000
) (
    input  logic                clk24,
    input  logic                rst_n,
    // Main CPU
    input  logic                sec0,
    input  cop_pkg::cpu_word_t  mcu_din,
    input  logic [2:0]          cpu_sec,
    output cop_pkg::cpu_word_t  mcu_dout,
    // MCU ports
    input  cop_pkg::mcu_byte_t  p0_o,
    input  cop_pkg::mcu_byte_t  p1_o,
    input  cop_pkg::mcu_byte_t  p2_o,
    input  cop_pkg::mcu_byte_t  p3_o,
    output cop_pkg::mcu_byte_t  p0_i,
    output cop_pkg::mcu_byte_t  p3_i,
    output logic                mcu_intn,
    // Sound CPU and ADPCM requesters
    input  logic                snd_cs,
    input  cop_pkg::snd_addr_t  snd_addr,
    output cop_pkg::mcu_byte_t  snd_data,
    output logic                snd_ok,
    input  logic                adpcm_cs,
    input  cop_pkg::pcm_addr_t  adpcm_addr,
    output cop_pkg::mcu_byte_t  adpcm_data,
    output logic                adpcm_ok,
    // External sound ROM
    output logic                mem_cs,
    output cop_pkg::mem_addr_t  mem_addr,
    input  cop_pkg::mcu_byte_t  mem_data,
    input  logic                mem_ok
);
    import cop_pkg::*;

    logic      busy;
    sndflag_t  sndflag;
    crback_t   crback;

    mcu_port_latch u_latch (
        .clk24      ( clk24      ),
        .rst_n      ( rst_n      ),
        .sec0       ( sec0       ),
        .mcu_din    ( mcu_din    ),
        .p0_o       ( p0_o       ),
        .p2_o       ( p2_o       ),
        .p0_i       ( p0_i       ),
        .mcu_dout   ( mcu_dout   ),
        .mcu_intn   ( mcu_intn   )
    );

    bank_config u_banks (
        .clk24      ( clk24      ),
        .rst_n      ( rst_n      ),
        .p1_o       ( p1_o       ),
        .p3_o       ( p3_o       ),
        .cpu_sec    ( cpu_sec    ),
        .busy       ( busy       ),
        .p3_i       ( p3_i       ),
        .sndflag    ( sndflag    ),
        .crback     ( crback     )
    );

    rom_bank_map #(
        .snd_base   ( snd_base   ),
        .pcm_base   ( pcm_base   )
    ) u_map (
        .clk24      ( clk24      ),
        .rst_n      ( rst_n      ),
        .snd_cs     ( snd_cs     ),
        .snd_addr   ( snd_addr   ),
        .adpcm_cs   ( adpcm_cs   ),
        .adpcm_addr ( adpcm_addr ),
        .sndflag    ( sndflag    ),
        .crback     ( crback     ),
        .mem_data   ( mem_data   ),
        .mem_ok     ( mem_ok     ),
        .snd_data   ( snd_data   ),
        .snd_ok     ( snd_ok     ),
        .adpcm_data ( adpcm_data ),
        .adpcm_ok   ( adpcm_ok   ),
        .mem_cs     ( mem_cs     ),
        .mem_addr   ( mem_addr   ),
        .busy       ( busy       )
    );

endmodule

// ==== logic/rom_bank_map.sv ====
// Sound ROM mapper: banks sound and ADPCM addresses and shares one memory port

`timescale 1ns/1ps

module rom_bank_map #(
    parameter cop_pkg::mem_addr_t snd_base = 22'h000000,
    parameter cop_pkg::mem_addr_t pcm_base = 22'h040000
) (
    input  logic                clk24,
    input  logic                rst_n,
    input  logic                snd_cs,
    input  cop_pkg::snd_addr_t  snd_addr,
    input  logic                adpcm_cs,
    input  cop_pkg::pcm_addr_t  adpcm_addr,
    input  cop_pkg::sndflag_t   sndflag,
    input  cop_pkg::crback_t    crback,
    input  cop_pkg::mcu_byte_t  mem_data,
    input  logic                mem_ok,
    output cop_pkg::mcu_byte_t  snd_data,
    output logic                snd_ok,
    output cop_pkg::mcu_byte_t  adpcm_data,
    output logic                adpcm_ok,
    output logic                mem_cs,
    output cop_pkg::mem_addr_t  mem_addr,
    output logic                busy
);
    import cop_pkg::*;

    arb_state_t state;
    logic       last_pcm;

    // Address of the last fetch started per requester
    snd_addr_t  snd_served;
    pcm_addr_t  pcm_served;

    logic       snd_hit;
    logic       pcm_hit;
    logic       snd_pend;
    logic       pcm_pend;
    logic       pick_snd;
    logic       pick_pcm;
    mem_addr_t  snd_map;
    mem_addr_t  pcm_map;

    assign snd_hit  = snd_cs && (snd_addr == snd_served);
    assign pcm_hit  = adpcm_cs && (adpcm_addr == pcm_served);
    assign snd_pend = snd_cs && !snd_ok;
    assign pcm_pend = adpcm_cs && !adpcm_ok;

    // Alternate when both wait
    assign pick_snd = snd_pend && (!pcm_pend || last_pcm);
    assign pick_pcm = pcm_pend && !pick_snd;

    // Upper half of the sound space is banked after the fixed 32 kB
    always_comb begin
        if (snd_addr[15]) begin
            snd_map = snd_base + 22'h008000 + (mem_addr_t'(sndflag) << 15)
                    + mem_addr_t'(snd_addr[14:0]);
        end else begin
            snd_map = snd_base + mem_addr_t'(snd_addr);
        end
    end

    assign pcm_map = pcm_base + (mem_addr_t'(crback) << 16) + mem_addr_t'(adpcm_addr[15:0]);

    assign busy = (state != arb_idle);

    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            state    <= arb_idle;
            mem_cs   <= 1'b0;
            snd_ok   <= 1'b0;
            adpcm_ok <= 1'b0;
            last_pcm <= 1'b0;
        end else begin
            // New address or released cs drops ok
            if (!snd_hit) begin
                snd_ok <= 1'b0;
            end
            if (!pcm_hit) begin
                adpcm_ok <= 1'b0;
            end
            case (state)
                arb_idle: begin
                    if (pick_snd) begin
                        state  <= arb_snd;
                        mem_cs <= 1'b1;
                    end else if (pick_pcm) begin
                        state  <= arb_pcm;
                        mem_cs <= 1'b1;
                    end
                end
                arb_snd: begin
                    if (mem_ok) begin
                        state    <= arb_idle;
                        mem_cs   <= 1'b0;
                        snd_ok   <= snd_hit;
                        last_pcm <= 1'b0;
                    end
                end
                arb_pcm: begin
                    if (mem_ok) begin
                        state    <= arb_idle;
                        mem_cs   <= 1'b0;
                        adpcm_ok <= pcm_hit;
                        last_pcm <= 1'b1;
                    end
                end
                default: begin
                    state  <= arb_idle;
                    mem_cs <= 1'b0;
                end
            endcase
        end
    end

    // Address and data registers
    always_ff @(posedge clk24) begin
        if (state == arb_idle && pick_snd) begin
            mem_addr   <= snd_map;
            snd_served <= snd_addr;
        end else if (state == arb_idle && pick_pcm) begin
            mem_addr   <= pcm_map;
            pcm_served <= adpcm_addr;
        end
        if (state == arb_snd && mem_ok) begin
            snd_data <= mem_data;
        end
        if (state == arb_pcm && mem_ok) begin
            adpcm_data <= mem_data;
        end
    end

    // The memory sees one steady address for the whole access
    a_addr_stable : assert property (
        @(posedge clk24) disable iff (!rst_n)
        (mem_cs && !mem_ok) |=> $stable(mem_addr)
    ) else $error("mem_addr changed during a memory access");

endmodule

// ==== mcu_bridge/bank_config.sv ====
// Bank registers from MCU ports 1 and 3 that are held back while a ROM fetch runs

`timescale 1ns/1ps

module bank_config (
    input  logic                clk24,
    input  logic                rst_n,
    input  cop_pkg::mcu_byte_t  p1_o,
    input  cop_pkg::mcu_byte_t  p3_o,
    input  logic [2:0]          cpu_sec,
    input  logic                busy,
    output cop_pkg::mcu_byte_t  p3_i,
    output cop_pkg::sndflag_t   sndflag,
    output cop_pkg::crback_t    crback
);

    // CPU select lines read back on the upper bits of port 3
    assign p3_i = {cpu_sec, p3_o[4:0]};

    // Pending banks only reach the mapper in idle cycles
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            sndflag <= '0;
            crback  <= '0;
        end else if (!busy) begin
            sndflag <= p1_o[6:5];
            crback  <= p3_o[2:0];
        end
    end

endmodule

// ==== mcu_bridge/mcu_port_latch.sv ====
// MCU port bridge: strobe edge detection, byte latches and MCU interrupt

`timescale 1ns/1ps

module mcu_port_latch (
    input  logic                clk24,
    input  logic                rst_n,
    input  logic                sec0,
    input  cop_pkg::cpu_word_t  mcu_din,
    input  cop_pkg::mcu_byte_t  p0_o,
    input  cop_pkg::mcu_byte_t  p2_o,
    output cop_pkg::mcu_byte_t  p0_i,
    output cop_pkg::cpu_word_t  mcu_dout,
    output logic                mcu_intn
);
    import cop_pkg::*;

    // Registered samples and the sample one cycle older
    mcu_byte_t p2_q;
    mcu_byte_t p2_l;
    logic      sec0_q;
    logic      sec0_l;

    mcu_byte_t p2_rise;
    logic      sec0_rise;

    // All ones at reset so no edge fires on reset release
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            p2_q   <= '1;
            p2_l   <= '1;
            sec0_q <= 1'b1;
            sec0_l <= 1'b1;
        end else begin
            p2_q   <= p2_o;
            p2_l   <= p2_q;
            sec0_q <= sec0;
            sec0_l <= sec0_q;
        end
    end

    assign p2_rise   = p2_q & ~p2_l;
    assign sec0_rise = sec0_q & ~sec0_l;

    // Interrupt to the MCU, cleared by the MCU through p2 bit 3
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            mcu_intn <= 1'b1;
        end else if (!p2_q[3]) begin
            mcu_intn <= 1'b1;
        end else if (sec0_rise) begin
            mcu_intn <= 1'b0;
        end
    end

    // MCU reads the CPU word one byte at a time
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            p0_i <= '0;
        end else begin
            if (p2_rise[4]) begin
                p0_i <= mcu_din[15:8];
            end
            if (p2_rise[5]) begin
                p0_i <= mcu_din[7:0];
            end
        end
    end

    // MCU writes the reply word, low byte on bit 6 and high byte on bit 7
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            mcu_dout <= '0;
        end else begin
            if (p2_rise[6]) begin
                mcu_dout[7:0] <= p0_o;
            end
            if (p2_rise[7]) begin
                mcu_dout[15:8] <= p0_o;
            end
        end
    end

    // Both read strobes rising together would make p0_i ambiguous
    a_read_strobes_apart : assert property (
        @(posedge clk24) disable iff (!rst_n)
        !($rose(p2_o[4]) && $rose(p2_o[5]))
    ) else $error("p2_o bits 4 and 5 rose in the same cycle");

endmodule

// ==== common/cop_pkg.sv ====
// Shared types for the CPU, MCU and sound ROM glue of cop_link

package cop_pkg;

    // One byte on an MCU port or on the ROM data bus
    typedef logic [7:0] mcu_byte_t;

    // Main CPU data word as seen by the MCU bridge
    typedef logic [15:0] cpu_word_t;

    // Sound CPU byte address
    typedef logic [15:0] snd_addr_t;

    // ADPCM byte address, low 16 bits select inside a bank
    typedef logic [17:0] pcm_addr_t;

    // External ROM byte address
    typedef logic [21:0] mem_addr_t;

    // Sound CPU bank number from MCU port 1
    typedef logic [1:0] sndflag_t;

    // ADPCM bank number from MCU port 3
    typedef logic [2:0] crback_t;

    // ROM mapper states
    typedef enum logic [1:0] {
        arb_idle,
        arb_snd,
        arb_pcm
    } arb_state_t;

endpackage
